//--- flist.f
+incdir+bench
rtl/f2_pkg.sv
rtl/f2_addr_decode.sv
rtl/f2_sdram_port.sv
rtl/f2_bus_return.sv
rtl/f2_irq_ctrl.sv
rtl/f2_ss_sequencer.sv
rtl/f2_cpu_ctrl.sv
bench/tb_f2_cpu_ctrl.sv

//--- Makefile
TOP := tb_f2_cpu_ctrl

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --top-module f2_cpu_ctrl rtl/f2_pkg.sv \
		$(filter-out rtl/f2_pkg.sv,$(wildcard rtl/*.sv))
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o sim_top
	./obj_dir/sim_top | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/f2_tb_tasks.svh
`ifndef F2_TB_TASKS_SVH
`define F2_TB_TASKS_SVH

////////////////////////////////////////
// Error reporting and compares

task automatic abort_run(input string msg);
    errors++;
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at first error");
endtask

task automatic report_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    abort_run($sformatf("CHECK FAILED at %0t ns: %s = 0x%0h, expected 0x%0h",
                        $time, name, got, exp));
endtask

task automatic check_word(input string name, input f2_pkg::word_t got,
                          input f2_pkg::word_t exp);
    if (got !== exp) report_mismatch(name, {16'h0, got}, {16'h0, exp});
endtask

task automatic check_addr(input string name, input f2_pkg::sdr_addr_t got,
                          input f2_pkg::sdr_addr_t exp);
    if (got !== exp) report_mismatch(name, {5'h0, got}, {5'h0, exp});
endtask

task automatic check_ipl(input string name, input f2_pkg::ipl_n_t got,
                         input f2_pkg::ipl_n_t exp);
    if (got !== exp) report_mismatch(name, {29'h0, got}, {29'h0, exp});
endtask

task automatic check_ssp(input string name, input f2_pkg::ssp_t got,
                         input f2_pkg::ssp_t exp);
    if (got !== exp) report_mismatch(name, got, exp);
endtask

task automatic check_state(input string name, input f2_pkg::ss_state_t got,
                           input f2_pkg::ss_state_t exp);
    if (got !== exp) report_mismatch(name, {28'h0, got}, {28'h0, exp});
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) report_mismatch(name, {31'h0, got}, {31'h0, exp});
endtask

task automatic check_strobes(input string name, input f2_pkg::ds_n_t got,
                             input f2_pkg::ds_n_t exp);
    if (got !== exp) report_mismatch(name, {30'h0, got}, {30'h0, exp});
endtask

// Order is rom, work, screen, object, color, io, sound
task automatic check_selects(input string name, input logic [6:0] got,
                             input logic [6:0] exp);
    if (got !== exp) report_mismatch(name, {25'h0, got}, {25'h0, exp});
endtask

////////////////////////////////////////
// Bus cycle and waits

// Holds the cycle until DTACK, like the 68000
task automatic bus_cycle(input f2_pkg::byte_addr_t addr, input f2_pkg::ds_n_t ds,
                         input logic rw, input f2_pkg::fc_t f,
                         input f2_pkg::word_t wdata, output f2_pkg::word_t rdata);
    int cycles;
    @(posedge clk);
    #1;
    cpu_addr  = addr[23:1];
    ds_n      = ds;
    cpu_rw    = rw;
    fc        = f;
    cpu_wdata = wdata;
    @(posedge clk); // SDRAM request launches here
    cycles = 0;
    @(negedge clk);
    while (dtack_n) begin
        cycles++;
        if (cycles > 40) abort_run($sformatf("No DTACK for address 0x%06h", addr));
        @(negedge clk);
    end
    rdata   = cpu_rdata;
    cs_seen = {rom_n, work_n, screen_n, object_n, color_n, io_n, sound_n};
    @(posedge clk);
    #1;
    ds_n   = 2'b11;
    cpu_rw = 1'b1;
endtask

task automatic wait_ipl(input f2_pkg::ipl_n_t exp, input int limit);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (ipl_n !== exp) begin
        cycles++;
        if (cycles > limit) abort_run($sformatf("ipl_n never reached %b", exp));
        @(negedge clk);
    end
endtask

task automatic wait_state(input f2_pkg::ss_state_t exp, input int limit);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (f2_pkg::ss_state_t'(ss_state) != exp) begin
        cycles++;
        if (cycles > limit) abort_run($sformatf("ss_state never reached %s", exp.name()));
        @(negedge clk);
    end
endtask

////////////////////////////////////////
// Directed tests

task automatic check_after_reset();
    @(negedge clk);
    check_state("ss_state", f2_pkg::ss_state_t'(ss_state), f2_pkg::IDLE);
    check_ipl("ipl_n", ipl_n, 3'b111);
    check_bit("ss_write", ss_write, 1'b0);
    check_bit("ss_read", ss_read, 1'b0);
    check_bit("cpu_pause", cpu_pause, 1'b0);
    check_bit("cpu_reset", cpu_reset, 1'b0);
    check_bit("sdr_req", sdr_req, 1'b0);
    check_selects("chip selects", {rom_n, work_n, screen_n, object_n, color_n, io_n,
                                   sound_n}, 7'h7f);
endtask

task automatic test_sdram_cycles();
    f2_pkg::byte_addr_t addr;
    f2_pkg::sdr_addr_t  exp_addr;
    f2_pkg::word_t      rd;
    for (int i = 0; i < 4; i++) begin
        addr     = 24'h000400 + 24'(i) * 24'h002346;
        exp_addr = f2_pkg::CPU_ROM_SDR_BASE + {3'b000, addr};
        bus_cycle(addr, 2'b00, 1'b1, 3'b110, 16'h0000, rd);
        check_addr("sdr_addr", sdr_addr, exp_addr);
        check_bit("sdr_rw", sdr_rw, 1'b1);
        check_strobes("sdr_be", sdr_be, 2'b11);
        check_word("cpu_rdata", rd, exp_addr[15:0] ^ 16'h5a5a);
        check_selects("chip selects", cs_seen, 7'b0111111);
    end

    // Upper byte only
    addr     = 24'h100a20;
    exp_addr = f2_pkg::CPU_ROM_SDR_BASE + {3'b000, addr};
    bus_cycle(addr, 2'b01, 1'b0, 3'b101, 16'hb7e1, rd);
    check_addr("sdr_addr", sdr_addr, exp_addr);
    check_bit("sdr_rw", sdr_rw, 1'b0);
    check_word("sdr_data", sdr_data, 16'hb7e1);
    check_strobes("sdr_be", sdr_be, 2'b10);
    check_word("sdram word", sdr_mem[exp_addr[4:1]], 16'hb7e1);
    check_selects("chip selects", cs_seen, 7'b1011111);
endtask

task automatic test_peripheral_reads();
    f2_pkg::byte_addr_t addrs [7];
    f2_pkg::word_t      words [7];
    logic [6:0]         sels  [7];
    f2_pkg::word_t      rd;
    addrs = '{24'h800010, 24'h900020, 24'h200004, 24'h300006, 24'h320002,
              24'h00007c, 24'h00007e};
    words = '{16'h1357, 16'h2468, 16'h9abc, 16'h00c3, 16'h0a00, 16'h00ff, 16'h0000};
    sels  = '{7'b1101111, 7'b1110111, 7'b1111011, 7'b1111101, 7'b1111110,
              7'h7f, 7'h7f};
    for (int i = 0; i < 7; i++) begin
        bus_cycle(addrs[i], 2'b00, 1'b1, 3'b101, 16'h0000, rd);
        check_word($sformatf("cpu_rdata at 0x%06h", addrs[i]), rd, words[i]);
        check_selects($sformatf("chip selects at 0x%06h", addrs[i]), cs_seen, sels[i]);
    end
endtask

task automatic test_interrupts();
    f2_pkg::word_t rd;
    @(posedge clk);
    #1 vblank_n = 1'b0;
    wait_ipl(3'b010, 10);       // Level 5
    @(posedge clk);
    #1 dma_n = 1'b0;
    repeat (3) @(posedge clk);
    #1 check_ipl("ipl_n", ipl_n, 3'b010); // Falling DMA raises nothing
    dma_n = 1'b1;
    vblank_n = 1'b1;
    wait_ipl(3'b001, 10);       // Level 6
    bus_cycle(24'hfffffc, 2'b10, 1'b1, 3'b111, 16'h0000, rd);
    check_ipl("ipl_n", ipl_n, 3'b010);
    bus_cycle(24'hfffffa, 2'b10, 1'b1, 3'b111, 16'h0000, rd);
    check_ipl("ipl_n", ipl_n, 3'b111);
endtask

task automatic test_save_sequence();
    f2_pkg::word_t handler_rom [13];
    f2_pkg::word_t rd;
    handler_rom = '{16'h48e7, 16'hfffe, 16'h4e6e, 16'h2f0e, 16'h4df9, 16'h00ff, 16'h0000,
                    16'h2c8f, 16'h2c5f, 16'h4e66, 16'h4cdf, 16'h7fff, 16'h4e73};
    @(posedge clk);
    #1 ss_do_save = 1'b1;
    repeat (3) @(posedge clk);
    #1 check_ipl("ipl_n", ipl_n, 3'b000); // Level 7 from the rising edge
    ss_do_save = 1'b0;
    check_state("ss_state", f2_pkg::ss_state_t'(ss_state), f2_pkg::START_SAVE);
    for (int i = 0; i < 16; i++) begin
        bus_cycle(24'hff0000 + 24'(2 * i), 2'b00, 1'b1, 3'b110, 16'h0000, rd);
        if (i < 13) begin
            check_word($sformatf("handler word %0d", i), rd, handler_rom[i]);
        end else begin
            check_word($sformatf("handler word %0d", i), rd, 16'h0000);
        end
    end

    bus_cycle(f2_pkg::SS_SSP_HI_ADDR, 2'b00, 1'b0, 3'b101, SAVE_SSP[31:16], rd);
    check_state("ss_state", f2_pkg::ss_state_t'(ss_state), f2_pkg::WAIT_SAVE);
    bus_cycle(f2_pkg::SS_SSP_LO_ADDR, 2'b00, 1'b0, 3'b101, SAVE_SSP[15:0], rd);
    check_ssp("saved_ssp", saved_ssp, SAVE_SSP);
    check_bit("cpu_pause", cpu_pause, 1'b1);
    wait_state(f2_pkg::SAVE_PAUSED, 40);
    check_bit("ss_write", ss_write, 1'b1);
    wait_state(f2_pkg::IDLE, 40);
    check_bit("cpu_pause", cpu_pause, 1'b0);

    bus_cycle(24'hfffffe, 2'b10, 1'b1, 3'b111, 16'h0000, rd);
    check_ipl("ipl_n", ipl_n, 3'b111);
endtask

task automatic test_restore_sequence();
    f2_pkg::word_t vec_words [4];
    f2_pkg::word_t rd;
    vec_words = '{ENGINE_SSP[31:16], ENGINE_SSP[15:0], 16'h00ff, 16'h0008};
    @(posedge clk);
    #1 ss_do_restore = 1'b1;
    @(posedge clk);
    #1 ss_do_restore = 1'b0;
    wait_state(f2_pkg::RESTORE_SETTLE, 5);
    check_bit("cpu_reset", cpu_reset, 1'b1);
    wait_state(f2_pkg::WAIT_RESTORE, 20);
    check_bit("ss_read", ss_read, 1'b1);
    check_bit("cpu_pause", cpu_pause, 1'b1);
    wait_state(f2_pkg::HOLD_RESET, 40);
    check_bit("cpu_reset", cpu_reset, 1'b1);
    wait_state(f2_pkg::WAIT_RESET, 40);
    check_bit("cpu_reset", cpu_reset, 1'b0);

    // Reset vectors come from the sequencer while restarting
    for (int i = 0; i < 4; i++) begin
        bus_cycle(24'(2 * i), 2'b00, 1'b1, 3'b110, 16'h0000, rd);
        check_word($sformatf("reset vector word %0d", i), rd, vec_words[i]);
        check_selects("chip selects", cs_seen, 7'h7f);
    end

    bus_cycle(f2_pkg::SS_SSP_LO_ADDR, 2'b00, 1'b0, 3'b101, ENGINE_SSP[15:0], rd);
    check_state("ss_state", f2_pkg::ss_state_t'(ss_state), f2_pkg::IDLE);
endtask

`endif

//--- bench/tb_f2_cpu_ctrl.sv
`timescale 1ns/100ps

module tb_f2_cpu_ctrl;

    localparam f2_pkg::ssp_t ENGINE_SSP = 32'h00fe_51c0; // Store engine restore SSP
    localparam f2_pkg::ssp_t SAVE_SSP   = 32'h00fe_3a70; // SSP the handler pushes

    logic              clk;
    logic              reset;
    f2_pkg::cpu_addr_t cpu_addr;
    f2_pkg::ds_n_t     ds_n;
    logic              cpu_rw;
    f2_pkg::fc_t       fc;
    f2_pkg::word_t     cpu_wdata;
    f2_pkg::word_t     cpu_rdata;
    logic              dtack_n;
    f2_pkg::ipl_n_t    ipl_n;
    logic              cpu_pause;
    logic              cpu_reset;
    logic              rom_n, work_n, screen_n, object_n, color_n, io_n, sound_n;
    f2_pkg::word_t     scn_rdata, obj_rdata, pri_rdata;
    logic [7:0]        io_rdata;
    logic [3:0]        snd_rdata;
    logic              scn_dtack_n, pri_dtack_n;
    logic              vblank_n, dma_n;
    f2_pkg::sdr_addr_t sdr_addr;
    f2_pkg::word_t     sdr_data;
    f2_pkg::ds_n_t     sdr_be;
    logic              sdr_rw, sdr_req, sdr_ack;
    f2_pkg::word_t     sdr_q;
    logic              ss_do_save, ss_do_restore, ss_busy;
    f2_pkg::ssp_t      restore_ssp, saved_ssp;
    logic              ss_write, ss_read;
    logic [3:0]        ss_state;

    integer            seed = 32'h8da8_3763;
    int                errors = 0;
    f2_pkg::word_t     sdr_mem [16];  // Written words, by sdr_addr[4:1]
    logic [6:0]        cs_seen;       // Chip selects sampled with the read data

    f2_cpu_ctrl #(
        .SETTLE_CYCLES(8),
        .HOLD_CYCLES  (20)
    ) uut (.*);

    `include "f2_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////
    // SDRAM model

    initial begin
        int delay;
        sdr_ack = 1'b0;
        sdr_q   = 16'h0000;
        forever begin
            @(posedge clk);
            #1;
            if (sdr_req != sdr_ack) begin
                delay = 1 + int'({$random(seed)} % 32'd6);
                repeat (delay) @(posedge clk);
                #1;
                if (!sdr_rw) sdr_mem[sdr_addr[4:1]] = sdr_data;
                sdr_q   = sdr_addr[15:0] ^ 16'h5a5a;
                sdr_ack = sdr_req; // Completes the toggle
            end
        end
    end

    ////////////////////////////////////////
    // Store engine model

    initial begin
        ss_busy     = 1'b0;
        restore_ssp = ENGINE_SSP;
        forever begin
            @(posedge clk);
            #1;
            if (ss_write || ss_read) begin
                repeat (2) @(posedge clk);
                #1 ss_busy = 1'b1;
                repeat (5) @(posedge clk);
                #1 ss_busy = 1'b0;
            end
        end
    end

    initial begin
        reset         = 1'b1;
        cpu_addr      = '0;
        ds_n          = 2'b11;
        cpu_rw        = 1'b1;
        fc            = 3'b000;
        cpu_wdata     = 16'h0000;
        scn_rdata     = 16'h1357;
        obj_rdata     = 16'h2468;
        pri_rdata     = 16'h9abc;
        io_rdata      = 8'hc3;
        snd_rdata     = 4'ha;
        scn_dtack_n   = 1'b0;
        pri_dtack_n   = 1'b0;
        vblank_n      = 1'b1;
        dma_n         = 1'b1;
        ss_do_save    = 1'b0;
        ss_do_restore = 1'b0;
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;

        check_after_reset();
        test_sdram_cycles();
        test_peripheral_reads();
        test_interrupts();
        test_save_sequence();
        test_restore_sequence();
        repeat (4) @(posedge clk);

        if (errors == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "checks failed");
        end
    end

endmodule

//--- rtl/f2_cpu_ctrl.sv
`timescale 1ns/100ps

module f2_cpu_ctrl #(
    parameter int SETTLE_CYCLES = 64,
    parameter int HOLD_CYCLES   = 1000
) (
    input  logic              clk,
    input  logic              reset,

    // CPU bus
    input  f2_pkg::cpu_addr_t cpu_addr,
    input  f2_pkg::ds_n_t     ds_n,
    input  logic              cpu_rw,
    input  f2_pkg::fc_t       fc,
    input  f2_pkg::word_t     cpu_wdata,
    output f2_pkg::word_t     cpu_rdata,
    output logic              dtack_n,
    output f2_pkg::ipl_n_t    ipl_n,
    output logic              cpu_pause,
    output logic              cpu_reset,

    // Chip selects
    output logic              rom_n,
    output logic              work_n,
    output logic              screen_n,
    output logic              object_n,
    output logic              color_n,
    output logic              io_n,
    output logic              sound_n,

    // Peripherals
    input  f2_pkg::word_t     scn_rdata,
    input  f2_pkg::word_t     obj_rdata,
    input  f2_pkg::word_t     pri_rdata,
    input  logic [7:0]        io_rdata,
    input  logic [3:0]        snd_rdata,
    input  logic              scn_dtack_n,
    input  logic              pri_dtack_n,
    input  logic              vblank_n,
    input  logic              dma_n,

    // SDRAM
    output f2_pkg::sdr_addr_t sdr_addr,
    output f2_pkg::word_t     sdr_data,
    output f2_pkg::ds_n_t     sdr_be,
    output logic              sdr_rw,
    output logic              sdr_req,
    input  logic              sdr_ack,
    input  f2_pkg::word_t     sdr_q,

    // Store engine
    input  logic              ss_do_save,
    input  logic              ss_do_restore,
    input  logic              ss_busy,
    input  f2_pkg::ssp_t      restore_ssp,
    output logic              ss_write,
    output logic              ss_read,
    output f2_pkg::ssp_t      saved_ssp,
    output logic [3:0]        ss_state
);

    f2_pkg::region_t   region;
    f2_pkg::ssp_t      latched_ssp;
    f2_pkg::ss_state_t state;
    logic              restart;
    logic              sdr_busy;

    assign ss_state = state;

    assign rom_n    = region != f2_pkg::ROM;
    assign work_n   = region != f2_pkg::WORK;
    assign screen_n = region != f2_pkg::SCREEN;
    assign object_n = region != f2_pkg::OBJECT;
    assign color_n  = region != f2_pkg::COLOR;
    assign io_n     = region != f2_pkg::IO;
    assign sound_n  = region != f2_pkg::SOUND;

    ////////////////////////////////////////
    // Bus path

    f2_addr_decode u_decode (
        .cpu_addr, .ds_n, .restart, .region
    );

    f2_sdram_port u_sdram (
        .clk, .reset, .region, .cpu_addr, .ds_n, .cpu_rw, .cpu_wdata,
        .sdr_addr, .sdr_data, .sdr_be, .sdr_rw, .sdr_req, .sdr_ack,
        .busy(sdr_busy)
    );

    f2_bus_return u_return (
        .region, .cpu_addr, .sdr_q, .scn_rdata, .obj_rdata, .pri_rdata,
        .io_rdata, .snd_rdata, .restore_ssp(latched_ssp), .sdr_busy,
        .scn_dtack_n, .pri_dtack_n, .cpu_rdata, .dtack_n
    );

    ////////////////////////////////////////
    // Controllers

    f2_irq_ctrl u_irq (
        .clk, .reset, .vblank_n, .dma_n, .ss_do_save, .fc, .cpu_addr, .ds_n, .ipl_n
    );

    f2_ss_sequencer #(
        .SETTLE_CYCLES(SETTLE_CYCLES),
        .HOLD_CYCLES  (HOLD_CYCLES)
    ) u_seq (
        .clk, .reset, .ss_do_save, .ss_do_restore, .cpu_addr, .ds_n, .cpu_rw,
        .cpu_wdata, .ss_busy, .restore_ssp_in(restore_ssp), .saved_ssp,
        .restore_ssp(latched_ssp), .ss_write, .ss_read, .cpu_pause, .cpu_reset,
        .restart, .ss_state(state)
    );

endmodule

//--- rtl/f2_ss_sequencer.sv
`timescale 1ns/100ps

module f2_ss_sequencer #(
    parameter int SETTLE_CYCLES = 64,
    parameter int HOLD_CYCLES   = 1000
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              ss_do_save,
    input  logic              ss_do_restore,
    input  f2_pkg::cpu_addr_t cpu_addr,
    input  f2_pkg::ds_n_t     ds_n,
    input  logic              cpu_rw,
    input  f2_pkg::word_t     cpu_wdata,
    input  logic              ss_busy,
    input  f2_pkg::ssp_t      restore_ssp_in,
    output f2_pkg::ssp_t      saved_ssp,
    output f2_pkg::ssp_t      restore_ssp,
    output logic              ss_write,
    output logic              ss_read,
    output logic              cpu_pause,
    output logic              cpu_reset,
    output logic              restart,
    output f2_pkg::ss_state_t ss_state
);

    logic [15:0] counter;
    logic        word_wr;
    logic        hi_wr, lo_wr;

    assign word_wr = (ds_n == 2'b00) && !cpu_rw;
    assign hi_wr   = word_wr && ({cpu_addr, 1'b0} == f2_pkg::SS_SSP_HI_ADDR);
    assign lo_wr   = word_wr && ({cpu_addr, 1'b0} == f2_pkg::SS_SSP_LO_ADDR);

    assign cpu_pause = (ss_state == f2_pkg::SAVE_PAUSED_SETTLE) ||
                       (ss_state == f2_pkg::SAVE_PAUSED) ||
                       (ss_state == f2_pkg::WAIT_RESTORE);
    assign cpu_reset = (ss_state == f2_pkg::HOLD_RESET) ||
                       (ss_state == f2_pkg::RESTORE_SETTLE);
    assign restart   = ss_state == f2_pkg::WAIT_RESET;

    always_ff @(posedge clk) begin
        if (reset) begin
            ss_state <= f2_pkg::IDLE;
            counter  <= 16'd0;
            ss_write <= 1'b0;
            ss_read  <= 1'b0;
        end else begin
            counter <= counter + 16'd1;
            case (ss_state)
                f2_pkg::IDLE: begin
                    if (ss_do_save) begin
                        ss_state <= f2_pkg::START_SAVE;
                    end else if (ss_do_restore) begin
                        ss_state <= f2_pkg::RESTORE_SETTLE;
                        counter  <= 16'd0;
                    end
                end
                f2_pkg::START_SAVE: begin
                    if (hi_wr) ss_state <= f2_pkg::WAIT_SAVE;
                end
                f2_pkg::WAIT_SAVE: begin
                    if (lo_wr) begin
                        ss_state <= f2_pkg::SAVE_PAUSED_SETTLE;
                        counter  <= 16'd0;
                    end
                end
                f2_pkg::SAVE_PAUSED_SETTLE: begin
                    if (counter == 16'(SETTLE_CYCLES)) begin
                        ss_write <= 1'b1;
                        ss_state <= f2_pkg::SAVE_PAUSED;
                    end
                end
                f2_pkg::SAVE_PAUSED: begin
                    if (ss_busy && ss_write) begin
                        ss_write <= 1'b0; // Engine took the start
                    end else if (!ss_busy && !ss_write) begin
                        ss_state <= f2_pkg::IDLE;
                    end
                end
                f2_pkg::RESTORE_SETTLE: begin
                    if (counter == 16'(SETTLE_CYCLES)) begin
                        ss_read  <= 1'b1;
                        ss_state <= f2_pkg::WAIT_RESTORE;
                    end
                end
                f2_pkg::WAIT_RESTORE: begin
                    if (ss_busy && ss_read) begin
                        ss_read <= 1'b0;
                    end else if (!ss_busy && !ss_read) begin
                        ss_state <= f2_pkg::HOLD_RESET;
                        counter  <= 16'd0;
                    end
                end
                f2_pkg::HOLD_RESET: begin
                    if (counter == 16'(HOLD_CYCLES)) ss_state <= f2_pkg::WAIT_RESET;
                end
                f2_pkg::WAIT_RESET: begin
                    if (lo_wr) ss_state <= f2_pkg::IDLE; // Handler has restored SSP
                end
                default: ss_state <= f2_pkg::IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // Stack pointer capture

    always_ff @(posedge clk) begin
        if (ss_state == f2_pkg::START_SAVE && hi_wr) saved_ssp[31:16] <= cpu_wdata;
        if (ss_state == f2_pkg::WAIT_SAVE && lo_wr) saved_ssp[15:0] <= cpu_wdata;
        if (ss_state == f2_pkg::WAIT_RESTORE && !ss_busy && !ss_read) begin
            restore_ssp <= restore_ssp_in;
        end
    end

    assert property (@(posedge clk) disable iff (reset) !(ss_write && ss_read));

endmodule

//--- rtl/f2_irq_ctrl.sv
`timescale 1ns/100ps

module f2_irq_ctrl (
    input  logic              clk,
    input  logic              reset,
    input  logic              vblank_n,
    input  logic              dma_n,
    input  logic              ss_do_save,
    input  f2_pkg::fc_t       fc,
    input  f2_pkg::cpu_addr_t cpu_addr,
    input  f2_pkg::ds_n_t     ds_n,
    output f2_pkg::ipl_n_t    ipl_n
);

    logic vbl_q, vbl_prev;
    logic dma_q, dma_prev;
    logic save_q, save_prev;
    logic req1, req2, save_req;
    logic iack;

    // Autovector acknowledge on the lower strobe
    assign iack = (fc == 3'b111) && !ds_n[0];

    always_ff @(posedge clk) begin
        if (reset) begin
            vbl_q     <= 1'b1;
            vbl_prev  <= 1'b1;
            dma_q     <= 1'b1;
            dma_prev  <= 1'b1;
            save_q    <= 1'b0;
            save_prev <= 1'b0;
            req1      <= 1'b0;
            req2      <= 1'b0;
            save_req  <= 1'b0;
        end else begin
            vbl_q     <= vblank_n;
            vbl_prev  <= vbl_q;
            dma_q     <= dma_n;
            dma_prev  <= dma_q;
            save_q    <= ss_do_save;
            save_prev <= save_q;

            if (vbl_prev && !vbl_q) req1 <= 1'b1;        // Falling vblank
            if (!dma_prev && dma_q) req2 <= 1'b1;        // End of object DMA
            if (!save_prev && save_q) save_req <= 1'b1;

            // Acknowledge wins over a new edge
            if (iack && cpu_addr[2:0] == 3'b101) req1 <= 1'b0;
            if (iack && cpu_addr[2:0] == 3'b110) req2 <= 1'b0;
            if (iack && cpu_addr[2:0] == 3'b111) save_req <= 1'b0;
        end
    end

    assign ipl_n = save_req ? ~3'd7 :
                   req2     ? ~3'd6 :
                   req1     ? ~3'd5 :
                              ~3'd0;

    // A level only drops after an acknowledge
    assert property (@(posedge clk) disable iff (reset)
        ((~ipl_n) < $past(~ipl_n)) |-> $past(iack));

endmodule

//--- rtl/f2_bus_return.sv
`timescale 1ns/100ps

module f2_bus_return (
    input  f2_pkg::region_t   region,
    input  f2_pkg::cpu_addr_t cpu_addr,
    input  f2_pkg::word_t     sdr_q,
    input  f2_pkg::word_t     scn_rdata,
    input  f2_pkg::word_t     obj_rdata,
    input  f2_pkg::word_t     pri_rdata,
    input  logic [7:0]        io_rdata,
    input  logic [3:0]        snd_rdata,
    input  f2_pkg::ssp_t      restore_ssp,
    input  logic              sdr_busy,
    input  logic              scn_dtack_n,
    input  logic              pri_dtack_n,
    output f2_pkg::word_t     cpu_rdata,
    output logic              dtack_n
);

    f2_pkg::word_t handler_word;
    f2_pkg::word_t reset_word;

    ////////////////////////////////////////
    // Save handler ROM

    // Saves registers, pushes SSP to 0xff0000, then stops
    always_comb begin
        case (cpu_addr[3:0])
            4'd0:    handler_word = 16'h48e7;
            4'd1:    handler_word = 16'hfffe;
            4'd2:    handler_word = 16'h4e6e;
            4'd3:    handler_word = 16'h2f0e;
            4'd4:    handler_word = 16'h4df9; // Restart entry
            4'd5:    handler_word = 16'h00ff;
            4'd6:    handler_word = 16'h0000;
            4'd7:    handler_word = 16'h2c8f;
            4'd8:    handler_word = 16'h2c5f;
            4'd9:    handler_word = 16'h4e66;
            4'd10:   handler_word = 16'h4cdf;
            4'd11:   handler_word = 16'h7fff;
            4'd12:   handler_word = 16'h4e73; // rte
            default: handler_word = 16'h0000;
        endcase
    end

    // Reset vectors while restarting
    always_comb begin
        case (cpu_addr[1:0])
            2'd0:    reset_word = restore_ssp[31:16];
            2'd1:    reset_word = restore_ssp[15:0];
            2'd2:    reset_word = f2_pkg::RESTART_PC_HI;
            default: reset_word = f2_pkg::RESTART_PC_LO;
        endcase
    end

    ////////////////////////////////////////
    // Read data select

    always_comb begin
        case (region)
            f2_pkg::ROM,
            f2_pkg::WORK:     cpu_rdata = sdr_q;
            f2_pkg::SCREEN:   cpu_rdata = scn_rdata;
            f2_pkg::OBJECT:   cpu_rdata = obj_rdata;
            f2_pkg::COLOR:    cpu_rdata = pri_rdata;
            f2_pkg::IO:       cpu_rdata = {8'h00, io_rdata};
            f2_pkg::SOUND:    cpu_rdata = {4'h0, snd_rdata, 8'h00};
            f2_pkg::SS_SAVE:  cpu_rdata = handler_word;
            f2_pkg::SS_RESET: cpu_rdata = reset_word;
            f2_pkg::SS_VEC:   cpu_rdata = cpu_addr[0] ? 16'h0000 : 16'h00ff;
            default:          cpu_rdata = 16'h0000;
        endcase
    end

    assign dtack_n = sdr_busy | scn_dtack_n | pri_dtack_n;

endmodule

//--- rtl/f2_sdram_port.sv
`timescale 1ns/100ps

module f2_sdram_port (
    input  logic              clk,
    input  logic              reset,
    input  f2_pkg::region_t   region,
    input  f2_pkg::cpu_addr_t cpu_addr,
    input  f2_pkg::ds_n_t     ds_n,
    input  logic              cpu_rw,
    input  f2_pkg::word_t     cpu_wdata,
    output f2_pkg::sdr_addr_t sdr_addr,
    output f2_pkg::word_t     sdr_data,
    output f2_pkg::ds_n_t     sdr_be,
    output logic              sdr_rw,   // High for read
    output logic              sdr_req,
    input  logic              sdr_ack,
    output logic              busy
);

    logic prev_idle; // All strobes high last cycle
    logic start;

    assign start = ((region == f2_pkg::ROM) || (region == f2_pkg::WORK)) && prev_idle;
    assign busy  = sdr_req != sdr_ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            prev_idle <= 1'b1;
            sdr_req   <= 1'b0;
        end else begin
            prev_idle <= &ds_n;
            if (start) begin
                sdr_req <= ~sdr_req;
            end
        end
    end

    // Payload only moves on a cycle start
    always_ff @(posedge clk) begin
        if (start) begin
            sdr_addr <= f2_pkg::CPU_ROM_SDR_BASE + {3'b000, cpu_addr, 1'b0};
            sdr_data <= cpu_wdata;
            sdr_be   <= ~ds_n;
            sdr_rw   <= cpu_rw;
        end
    end

    // A new request only goes out once the last one completed
    assert property (@(posedge clk) disable iff (reset)
        (sdr_req != $past(sdr_req)) |-> $past(sdr_req == sdr_ack));

endmodule

//--- rtl/f2_addr_decode.sv
`timescale 1ns/100ps

module f2_addr_decode (
    input  f2_pkg::cpu_addr_t cpu_addr,
    input  f2_pkg::ds_n_t     ds_n,
    input  logic              restart,
    output f2_pkg::region_t   region
);

    f2_pkg::byte_addr_t byte_addr;

    assign byte_addr = {cpu_addr, 1'b0};

    // First match wins, so the vector words sit ahead of the ROM nibble
    always_comb begin
        region = f2_pkg::NONE;
        if (~&ds_n) begin
            casez (byte_addr)
                24'h00000?: begin
                    if (restart) begin
                        region = f2_pkg::SS_RESET;
                    end else begin
                        region = f2_pkg::ROM;
                    end
                end
                24'h00007c: region = f2_pkg::SS_VEC;
                24'h00007e: region = f2_pkg::SS_VEC;
                24'h0?????: region = f2_pkg::ROM;
                24'h1?????: region = f2_pkg::WORK;
                24'h8?????: region = f2_pkg::SCREEN;
                24'h9?????: region = f2_pkg::OBJECT;
                24'h2?????: region = f2_pkg::COLOR;
                24'h30????: region = f2_pkg::IO;
                24'h32????: region = f2_pkg::SOUND;
                24'hff00??: region = f2_pkg::SS_SAVE;
                default:    region = f2_pkg::NONE;
            endcase
        end
    end

endmodule

//--- rtl/f2_pkg.sv
package f2_pkg;

    ////////////////////////////////////////
    // Bus widths

    typedef logic [15:0] word_t;      // CPU data word
    typedef logic [22:0] cpu_addr_t;  // CPU word address
    typedef logic [23:0] byte_addr_t; // Word address with A0 appended
    typedef logic [1:0]  ds_n_t;      // {UDS_n, LDS_n}
    typedef logic [2:0]  fc_t;
    typedef logic [2:0]  ipl_n_t;
    typedef logic [26:0] sdr_addr_t;
    typedef logic [31:0] ssp_t;

    ////////////////////////////////////////
    // Address regions seen by the CPU

    typedef enum logic [3:0] {
        NONE,
        ROM,
        WORK,
        SCREEN,
        OBJECT,
        COLOR,
        IO,
        SOUND,
        SS_SAVE,   // Built-in save handler
        SS_RESET,  // Restart reset vectors
        SS_VEC     // Level 7 vector override
    } region_t;

    typedef enum logic [3:0] {
        IDLE               = 4'd0,
        START_SAVE         = 4'd1,
        WAIT_SAVE          = 4'd2,
        SAVE_PAUSED_SETTLE = 4'd3,
        SAVE_PAUSED        = 4'd4,
        RESTORE_SETTLE     = 4'd5,
        WAIT_RESTORE       = 4'd6,
        HOLD_RESET         = 4'd7,
        WAIT_RESET         = 4'd8
    } ss_state_t;

    ////////////////////////////////////////
    // Fixed addresses and words

    localparam sdr_addr_t CPU_ROM_SDR_BASE = 27'h0200000;

    // Handler pushes the SSP here, high word first
    localparam byte_addr_t SS_SSP_HI_ADDR = 24'hff0000;
    localparam byte_addr_t SS_SSP_LO_ADDR = 24'hff0002;

    localparam word_t RESTART_PC_HI = 16'h00ff; // Restart PC points into handler
    localparam word_t RESTART_PC_LO = 16'h0008;

endpackage
